// File: vlog.f
slurm16_pipe_pkg.sv
slurm16_pipe_slot.sv
slurm16_pc_gen.sv
slurm16_pipe_ctrl.sv
slurm16_pipeline.sv
tb_slurm16_pipeline.sv

// File: Makefile
LOG = sim.log

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
		--top-module tb_slurm16_pipeline -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean

// File: tb_slurm16_pipeline.sv
// Testbench for the SLURM16 fetch and issue pipeline
// Instruction memory model, LFSR stimulus, retire-order model and tag checks
`timescale 1ns/100ps
`default_nettype none

module tb_slurm16_pipeline;

	logic        CLK;
	logic        RSTb;
	logic        instruction_request;
	logic        instruction_valid;
	logic [14:0] instruction_address;
	logic [15:0] instruction_in;
	logic [14:0] instruction_address_in;
	logic [15:0] pipeline_stage_0;
	logic [15:0] pipeline_stage_1;
	logic [15:0] pipeline_stage_2;
	logic [15:0] pipeline_stage_3;
	logic [15:0] pipeline_stage_4;
	logic [15:0] pc_stage_4;
	logic        nop_stage_2;
	logic        nop_stage_4;
	logic        hazard_1;
	logic        hazard_2;
	logic        hazard_3;
	logic [3:0]  hazard_reg0;
	logic [3:0]  hazard_reg1;
	logic [3:0]  hazard_reg2;
	logic [3:0]  hazard_reg3;
	logic        modifies_flags0;
	logic        modifies_flags1;
	logic        modifies_flags2;
	logic        modifies_flags3;
	logic        halt_request;
	logic        wake_request;
	logic        load_pc_request;
	logic [15:0] load_pc_address;

	// Sequence controls, written by the main process, read by the driver
	logic hold_reset;
	logic halt_pulse;
	logic wake_pulse;
	logic fault_en;  // Random fetch-invalid cycles
	logic branch_en;
	logic hazard_en;

	logic [15:0] lfsr_state;
	logic [14:0] prev_addr;   // Address the memory saw last cycle
	logic [14:0] expected_pc; // Next word address that must retire
	logic        running;     // Stage payloads all defined
	logic [15:0] branch_words[$];   // Branching words, oldest first
	logic [14:0] branch_targets[$];
	int retire_count;
	int branch_count;
	int check_count;
	int error_count;
	int timeout_count;

	slurm16_pipeline dut0 (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state); // One step per bit
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Memory contents, a bit permutation of the address so every word differs
	function automatic logic [15:0] fetch_word(input logic [14:0] a);
		return {a[6:0], a[14:7], 1'b1} ^ 16'h5a3c;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("mismatch %s: expected %h, actual %h at %0t ns", name, expected, actual,
				$time);
		end
	endtask

	task automatic check_true(input string what, input logic cond);
		check_count++;
		assert (cond === 1'b1) else begin
			error_count++;
			$display("error: %s at %0t ns", what, $time);
		end
	endtask

	// Word leaving stage 4, order and contents
	task automatic check_retire();
		logic [14:0] addr;
		addr = pc_stage_4[15:1];
		check_value("retire address", {expected_pc, 1'b0}, pc_stage_4);
		check_value("retire word", fetch_word(addr), pipeline_stage_4);
		if (branch_words.size() > 0 && branch_words[0] == pipeline_stage_4) begin
			expected_pc = branch_targets.pop_front(); // Branched from stage 2
			void'(branch_words.pop_front());
		end else begin
			expected_pc = addr + 15'd1;
		end
		retire_count++;
		running = 1'b1;
	endtask

	task automatic check_tags();
		check_value("stage 1 register tag", {12'h0, pipeline_stage_1[3:0]}, {12'h0, hazard_reg1});
		check_value("stage 2 register tag", {12'h0, pipeline_stage_2[3:0]}, {12'h0, hazard_reg2});
		check_value("stage 3 register tag", {12'h0, pipeline_stage_3[3:0]}, {12'h0, hazard_reg3});
		check_value("stage 1 flags tag", {15'h0, pipeline_stage_1[4]}, {15'h0, modifies_flags1});
		check_value("stage 2 flags tag", {15'h0, pipeline_stage_2[4]}, {15'h0, modifies_flags2});
		check_value("stage 3 flags tag", {15'h0, pipeline_stage_3[4]}, {15'h0, modifies_flags3});
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		logic good;
		good = 1'b1;
		if (fault_en) begin
			r = random_bits(3);
			good = (r != 32'd0); // Bad word 1 cycle in 8
		end
		// Word for last cycle's address, corrupted when not valid
		instruction_valid      = good;
		instruction_address_in = prev_addr;
		instruction_in         = good ? fetch_word(prev_addr) : ~fetch_word(prev_addr);
		prev_addr              = instruction_address;
		hazard_reg0     = pipeline_stage_0[3:0];
		modifies_flags0 = pipeline_stage_0[4];
		hazard_1 = 1'b0;
		hazard_2 = 1'b0;
		hazard_3 = 1'b0;
		if (hazard_en) begin
			r = random_bits(4);
			hazard_1 = (r[3:0] == 4'd0);
			r = random_bits(4);
			hazard_2 = (r[3:0] == 4'd0);
			r = random_bits(4);
			hazard_3 = (r[3:0] == 4'd0);
		end
		load_pc_request = 1'b0;
		if (branch_en && RSTb && !nop_stage_2) begin
			r = random_bits(8);
			if (r % 10 == 0) begin // About 1 in 10 live words branch
				r = random_bits(15);
				load_pc_request = 1'b1;
				load_pc_address = {r[14:0], 1'b0};
				branch_words.push_back(pipeline_stage_2);
				branch_targets.push_back(r[14:0]);
				branch_count++;
			end
		end
		RSTb         = ~hold_reset;
		halt_request = halt_pulse;
		wake_request = wake_pulse;
	endtask

	// Checks then drives, 2 ns after each rising edge
	initial begin
		forever begin
			@(posedge CLK);
			#2;
			if (RSTb && !nop_stage_4)
				check_retire();
			if (running)
				check_tags();
			drive_inputs();
		end
	end

	task automatic next_cycle();
		@(posedge CLK);
		#1; // Outputs settled, driver not yet run
	endtask

	task automatic wait_retired(input int count, input int limit);
		int goal;
		int n;
		goal = retire_count + count;
		n = 0;
		while (retire_count < goal && n < limit) begin
			next_cycle();
			n++;
		end
		if (retire_count < goal) begin
			timeout_count++;
			$display("timeout: %0d words retired, %0d needed, after %0d cycles", retire_count,
				goal, limit);
		end
	endtask

	// Halt pulse, request must drop within 20 cycles, wake 30 cycles after the pulse
	task automatic halt_and_wake();
		int i;
		logic fell;
		fell = 1'b0;
		halt_pulse = 1'b1;
		for (i = 1; i <= 30; i++) begin
			next_cycle();
			halt_pulse = 1'b0;
			if (!instruction_request)
				fell = 1'b1;
			else if (fell)
				check_true("instruction request rose while halted", 1'b0);
			if (i == 20 && !fell) begin
				timeout_count++;
				$display("timeout: instruction request still high 20 cycles after halt");
			end
		end
		wake_pulse = 1'b1;
		next_cycle();
		wake_pulse = 1'b0;
		check_true("instruction request not back after wake", instruction_request);
		wait_retired(1, 100); // Resumes at the expected address
	endtask

	initial begin
		int i;
		RSTb              = 1'b0;
		instruction_valid = 1'b0;
		instruction_in    = '0;
		instruction_address_in = '0;
		hazard_1        = 1'b0;
		hazard_2        = 1'b0;
		hazard_3        = 1'b0;
		hazard_reg0     = '0;
		modifies_flags0 = 1'b0;
		halt_request    = 1'b0;
		wake_request    = 1'b0;
		load_pc_request = 1'b0;
		load_pc_address = '0;
		hold_reset = 1'b1;
		halt_pulse = 1'b0;
		wake_pulse = 1'b0;
		fault_en   = 1'b0;
		branch_en  = 1'b0;
		hazard_en  = 1'b0;
		lfsr_state  = 16'd74;
		prev_addr   = '0;
		expected_pc = '0; // First word retired is address 0
		running     = 1'b0;
		retire_count  = 0;
		branch_count  = 0;
		check_count   = 0;
		error_count   = 0;
		timeout_count = 0;

		// Reset, then two cycles after it
		for (i = 0; i < 10; i++) begin
			next_cycle();
			if (i == 7)
				hold_reset = 1'b0;
			check_true("stage 2 live around reset", nop_stage_2);
			check_true("stage 4 live around reset", nop_stage_4);
			check_true("no instruction request around reset", instruction_request);
		end

		fault_en = 1'b1;
		wait_retired(60, 400);
		branch_en = 1'b1;
		wait_retired(100, 1000);
		check_true("no branch was issued", branch_count > 0);
		hazard_en = 1'b1;
		wait_retired(150, 2000);

		branch_en = 1'b0; // Nothing to delay the halt
		hazard_en = 1'b0;
		halt_and_wake();
		halt_and_wake();

		branch_en = 1'b1;
		hazard_en = 1'b1;
		wait_retired(100, 1500);

		$display("checks %0d, errors %0d, timeouts %0d, retired %0d, branches %0d",
			check_count, error_count, timeout_count, retire_count, branch_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: slurm16_pipeline.sv
// SLURM16 fetch and issue pipeline, top level
// Controller, fetch address generator and five stage slots
// Stages 1 to 3 carry the hazard tags alongside the word
`timescale 1ns/100ps
`default_nettype none

module slurm16_pipeline (
	input  wire                                    CLK,
	input  wire                                    RSTb,
	// Instruction fetch
	output logic                                   instruction_request,
	input  wire                                    instruction_valid,
	output slurm16_pipe_pkg::fetch_addr_t          instruction_address,
	input  wire slurm16_pipe_pkg::word_t           instruction_in,
	input  wire slurm16_pipe_pkg::fetch_addr_t     instruction_address_in,
	// Stage words
	output slurm16_pipe_pkg::word_t                pipeline_stage_0,
	output slurm16_pipe_pkg::word_t                pipeline_stage_1,
	output slurm16_pipe_pkg::word_t                pipeline_stage_2,
	output slurm16_pipe_pkg::word_t                pipeline_stage_3,
	output slurm16_pipe_pkg::word_t                pipeline_stage_4,
	output logic [slurm16_pipe_pkg::addr_bits-1:0] pc_stage_4,
	output logic                                   nop_stage_2, // Execute must not act
	output logic                                   nop_stage_4, // No writeback
	// Hazards
	input  wire                                    hazard_1,
	input  wire                                    hazard_2,
	input  wire                                    hazard_3,
	input  wire slurm16_pipe_pkg::haz_reg_t        hazard_reg0,
	input  wire                                    modifies_flags0,
	output slurm16_pipe_pkg::haz_reg_t             hazard_reg1,
	output slurm16_pipe_pkg::haz_reg_t             hazard_reg2,
	output slurm16_pipe_pkg::haz_reg_t             hazard_reg3,
	output logic                                   modifies_flags1,
	output logic                                   modifies_flags2,
	output logic                                   modifies_flags3,
	// Control
	input  wire                                    halt_request,
	input  wire                                    wake_request,
	input  wire                                    load_pc_request,
	input  wire [slurm16_pipe_pkg::addr_bits-1:0]  load_pc_address
);

	slurm16_pipe_pkg::ins_word_t    s0_d, s0_q, s4_q;
	slurm16_pipe_pkg::tagged_word_t s1_d, s1_q, s2_q, s3_q;
	slurm16_pipe_pkg::pc_cmd_t      pc_cmd;
	logic nop0, nop1, nop2, nop3, nop4;
	logic hold0, hold1;
	logic kill0, kill1, kill2, kill3, kill4;

	assign s0_d = '{ins: instruction_in, pc: instruction_address_in}; // Word and its own address
	assign s1_d = '{word: s0_q, haz_reg: hazard_reg0, mod_flags: modifies_flags0};

	slurm16_pipe_ctrl u_ctrl (
		.CLK(CLK), .RSTb(RSTb),
		.hazard_1(hazard_1), .hazard_2(hazard_2), .hazard_3(hazard_3),
		.load_pc_request(load_pc_request), .halt_request(halt_request),
		.wake_request(wake_request), .instruction_valid(instruction_valid),
		.nop0(nop0), .nop1(nop1), .nop2(nop2), .nop3(nop3),
		.instruction_request(instruction_request), .pc_cmd(pc_cmd),
		.hold0(hold0), .hold1(hold1),
		.kill0(kill0), .kill1(kill1), .kill2(kill2), .kill3(kill3), .kill4(kill4)
	);

	slurm16_pc_gen u_pc (
		.CLK(CLK), .pc_cmd(pc_cmd), .load_pc_address(load_pc_address),
		.restart_address(s2_q.word.pc), .instruction_address(instruction_address)
	);

	// Fetch, a returned word is live unless the controller kills it
	slurm16_pipe_slot #(.payload_t(slurm16_pipe_pkg::ins_word_t)) slot0 (
		.CLK(CLK), .RSTb(RSTb), .hold(hold0), .kill(kill0),
		.payload_in(s0_d), .nop_in(1'b0), .payload(s0_q), .nop(nop0)
	);
	slurm16_pipe_slot #(.payload_t(slurm16_pipe_pkg::tagged_word_t)) slot1 ( // Decode
		.CLK(CLK), .RSTb(RSTb), .hold(hold1), .kill(kill1),
		.payload_in(s1_d), .nop_in(nop0), .payload(s1_q), .nop(nop1)
	);
	slurm16_pipe_slot #(.payload_t(slurm16_pipe_pkg::tagged_word_t)) slot2 ( // Execute
		.CLK(CLK), .RSTb(RSTb), .hold(1'b0), .kill(kill2),
		.payload_in(s1_q), .nop_in(nop1), .payload(s2_q), .nop(nop2)
	);
	slurm16_pipe_slot #(.payload_t(slurm16_pipe_pkg::tagged_word_t)) slot3 ( // Memory
		.CLK(CLK), .RSTb(RSTb), .hold(1'b0), .kill(kill3),
		.payload_in(s2_q), .nop_in(nop2), .payload(s3_q), .nop(nop3)
	);
	// Writeback, tags no longer needed
	slurm16_pipe_slot #(.payload_t(slurm16_pipe_pkg::ins_word_t)) slot4 (
		.CLK(CLK), .RSTb(RSTb), .hold(1'b0), .kill(kill4),
		.payload_in(s3_q.word), .nop_in(nop3), .payload(s4_q), .nop(nop4)
	);

	assign pipeline_stage_0 = s0_q.ins;
	assign pipeline_stage_1 = s1_q.word.ins;
	assign pipeline_stage_2 = s2_q.word.ins;
	assign pipeline_stage_3 = s3_q.word.ins;
	assign pipeline_stage_4 = s4_q.ins;
	assign pc_stage_4       = {s4_q.pc, 1'b0}; // Back to a byte address
	assign nop_stage_2      = nop2;
	assign nop_stage_4      = nop4;

	assign hazard_reg1     = s1_q.haz_reg;
	assign hazard_reg2     = s2_q.haz_reg;
	assign hazard_reg3     = s3_q.haz_reg;
	assign modifies_flags1 = s1_q.mod_flags;
	assign modifies_flags2 = s2_q.mod_flags;
	assign modifies_flags3 = s3_q.mod_flags;

endmodule

`default_nettype wire

// File: slurm16_pipe_ctrl.sv
// SLURM16 pipeline controller
// State machine for hazard stalls, fetch-invalid stalls, branches and halt
// Drives per-stage hold and kill and the fetch address command
`timescale 1ns/100ps
`default_nettype none

module slurm16_pipe_ctrl (
	input  wire                        CLK,
	input  wire                        RSTb,
	input  wire                        hazard_1,          // Stage 0 against stage 1
	input  wire                        hazard_2,          // Stage 0 against stage 2
	input  wire                        hazard_3,          // Stage 0 against stage 3
	input  wire                        load_pc_request,   // Branch from stage 2
	input  wire                        halt_request,      // Pulse, latched here
	input  wire                        wake_request,
	input  wire                        instruction_valid,
	input  wire                        nop0,
	input  wire                        nop1,
	input  wire                        nop2,
	input  wire                        nop3,
	output logic                       instruction_request,
	output slurm16_pipe_pkg::pc_cmd_t  pc_cmd,
	output logic                       hold0,
	output logic                       hold1,
	output logic                       kill0,
	output logic                       kill1,
	output logic                       kill2,
	output logic                       kill3,
	output logic                       kill4
);

	slurm16_pipe_pkg::ctrl_state_t state_r;
	logic halt_lat_r;
	logic halt;
	logic stall_haz1;
	logic stall_haz2;
	logic stall_haz3;
	logic haz_stall;
	logic halt_take;
	logic flush;

	assign halt = halt_lat_r | halt_request;

	// Hazards only count for a live stage 0 word against a live older word
	assign stall_haz1 = hazard_1 & ~load_pc_request & ~nop0 & ~nop1;
	assign stall_haz2 = hazard_2 & ~load_pc_request & ~nop0 & ~nop2;
	assign stall_haz3 = hazard_3 & ~load_pc_request & ~nop0 & ~nop3;
	assign haz_stall  = stall_haz1 | stall_haz2 | stall_haz3;

	// Halt waits for a live stage 1 word, its address is where fetch resumes
	assign halt_take = (state_r == slurm16_pipe_pkg::st_execute) & halt & ~haz_stall
		& ~load_pc_request & ~nop1;

	assign flush = load_pc_request | halt_take; // Drop younger stages

	// Instruction memory is free in halt
	assign instruction_request = (state_r != slurm16_pipe_pkg::st_halt) &&
		(state_r != slurm16_pipe_pkg::st_halt2);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			halt_lat_r <= 1'b0;
		end else if (halt_take) begin
			halt_lat_r <= 1'b0; // Consumed on entry to halt
		end else if (halt_request) begin
			halt_lat_r <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state_r <= slurm16_pipe_pkg::st_reset;
		end else begin
			case (state_r)
				slurm16_pipe_pkg::st_reset:
					state_r <= slurm16_pipe_pkg::st_pre_execute;
				slurm16_pipe_pkg::st_pre_execute:
					state_r <= slurm16_pipe_pkg::st_execute;
				slurm16_pipe_pkg::st_execute: begin
					if (stall_haz1)
						state_r <= slurm16_pipe_pkg::st_stall1;
					else if (stall_haz2)
						state_r <= slurm16_pipe_pkg::st_stall2;
					else if (stall_haz3)
						state_r <= slurm16_pipe_pkg::st_stall3;
					else if (halt_take)
						state_r <= slurm16_pipe_pkg::st_halt;
					else if (load_pc_request)
						state_r <= slurm16_pipe_pkg::st_pre_execute;
					else if (!instruction_valid)
						state_r <= slurm16_pipe_pkg::st_ins_stall1; // Fetched word is bad
				end
				slurm16_pipe_pkg::st_stall1:
					state_r <= slurm16_pipe_pkg::st_stall2;
				slurm16_pipe_pkg::st_stall2, slurm16_pipe_pkg::st_stall3: begin
					if (load_pc_request)
						state_r <= slurm16_pipe_pkg::st_pre_execute;
					else if (state_r == slurm16_pipe_pkg::st_stall2)
						state_r <= slurm16_pipe_pkg::st_stall3;
					else
						state_r <= slurm16_pipe_pkg::st_execute;
				end
				slurm16_pipe_pkg::st_ins_stall1:
					state_r <= slurm16_pipe_pkg::st_ins_stall2; // PC rewind settles
				slurm16_pipe_pkg::st_ins_stall2: begin
					if (load_pc_request)
						state_r <= slurm16_pipe_pkg::st_pre_execute;
					else if (instruction_valid)
						state_r <= slurm16_pipe_pkg::st_execute;
				end
				slurm16_pipe_pkg::st_halt:
					state_r <= slurm16_pipe_pkg::st_halt2;
				slurm16_pipe_pkg::st_halt2: begin
					if (wake_request)
						state_r <= slurm16_pipe_pkg::st_pre_execute;
				end
				default:
					state_r <= slurm16_pipe_pkg::st_reset;
			endcase
		end
	end

	// Fetch address command
	always_comb begin
		pc_cmd = slurm16_pipe_pkg::pc_hold;
		case (state_r)
			slurm16_pipe_pkg::st_reset:       pc_cmd = slurm16_pipe_pkg::pc_zero;
			slurm16_pipe_pkg::st_pre_execute: pc_cmd = slurm16_pipe_pkg::pc_advance;
			slurm16_pipe_pkg::st_halt:        pc_cmd = slurm16_pipe_pkg::pc_restart;
			slurm16_pipe_pkg::st_execute: begin
				if (load_pc_request)
					pc_cmd = slurm16_pipe_pkg::pc_load;
				else if (haz_stall || !instruction_valid)
					pc_cmd = slurm16_pipe_pkg::pc_rewind; // Word in flight gets lost
				else
					pc_cmd = slurm16_pipe_pkg::pc_advance;
			end
			slurm16_pipe_pkg::st_stall1, slurm16_pipe_pkg::st_stall2,
			slurm16_pipe_pkg::st_ins_stall1: begin
				if (load_pc_request)
					pc_cmd = slurm16_pipe_pkg::pc_load;
			end
			slurm16_pipe_pkg::st_stall3, slurm16_pipe_pkg::st_ins_stall2: begin
				if (load_pc_request)
					pc_cmd = slurm16_pipe_pkg::pc_load;
				else if (state_r == slurm16_pipe_pkg::st_stall3 || instruction_valid)
					pc_cmd = slurm16_pipe_pkg::pc_advance; // Word arrives as execute resumes
			end
			default: ;
		endcase
	end

	// Per-stage hold and kill
	always_comb begin
		hold0 = 1'b1; // Stage 0 captures only in execute
		hold1 = 1'b0;
		kill0 = 1'b1;
		kill1 = 1'b0;
		kill2 = 1'b0;
		kill3 = 1'b0;
		kill4 = 1'b0;
		case (state_r)
			slurm16_pipe_pkg::st_execute: begin
				hold0 = 1'b0;
				kill0 = flush;
				kill1 = flush;
				kill2 = flush;
			end
			slurm16_pipe_pkg::st_stall1, slurm16_pipe_pkg::st_stall2,
			slurm16_pipe_pkg::st_stall3: begin
				hold1 = 1'b1;            // Hazard word waits in stage 1
				kill1 = load_pc_request;
				kill2 = 1'b1;            // Bubble into execute
			end
			slurm16_pipe_pkg::st_ins_stall1: begin
				kill1 = 1'b1; // Bad word from stage 0
				kill2 = load_pc_request;
			end
			slurm16_pipe_pkg::st_ins_stall2: begin
				kill1 = load_pc_request;
				kill2 = load_pc_request;
			end
			slurm16_pipe_pkg::st_pre_execute: begin
				kill1 = 1'b1;
				kill2 = 1'b1;
			end
			slurm16_pipe_pkg::st_halt: begin
				// Stage 3 word still writes back, fetch resumes behind it
				kill1 = 1'b1;
				kill2 = 1'b1;
				kill3 = 1'b1;
			end
			default: begin // Reset and halt2
				kill1 = 1'b1;
				kill2 = 1'b1;
				kill3 = 1'b1;
				kill4 = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: slurm16_pc_gen.sv
// SLURM16 fetch address generator
// Current and previous word address, driven by one command per cycle
// Previous address lets a fetch that could not be used be issued again
`timescale 1ns/100ps
`default_nettype none

module slurm16_pc_gen (
	input  wire                                          CLK,
	input  wire slurm16_pipe_pkg::pc_cmd_t               pc_cmd,
	input  wire [slurm16_pipe_pkg::addr_bits-1:0]        load_pc_address, // Byte address
	input  wire slurm16_pipe_pkg::fetch_addr_t           restart_address, // Stage 2 word
	output slurm16_pipe_pkg::fetch_addr_t                instruction_address
);

	slurm16_pipe_pkg::fetch_addr_t pc_r;
	slurm16_pipe_pkg::fetch_addr_t prev_pc_r; // Address issued one fetch ago
	slurm16_pipe_pkg::fetch_addr_t target;

	// Branch targets are even byte addresses
	assign target = load_pc_address[slurm16_pipe_pkg::addr_bits-1:1];

	assign instruction_address = pc_r;

	// Cleared by the zero command in the reset state
	always_ff @(posedge CLK) begin
		case (pc_cmd)
			slurm16_pipe_pkg::pc_zero: begin
				pc_r      <= '0;
				prev_pc_r <= '0;
			end
			slurm16_pipe_pkg::pc_advance: begin
				pc_r      <= pc_r + 1'b1;
				prev_pc_r <= pc_r;
			end
			slurm16_pipe_pkg::pc_rewind: begin
				pc_r <= prev_pc_r; // Previous stays, next advance refetches it
			end
			slurm16_pipe_pkg::pc_load: begin
				pc_r      <= target;
				prev_pc_r <= target;
			end
			slurm16_pipe_pkg::pc_restart: begin
				// Resume from the first word that did not complete before halt
				pc_r      <= restart_address;
				prev_pc_r <= restart_address;
			end
			default: begin
				pc_r      <= pc_r; // Hold
				prev_pc_r <= prev_pc_r;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: slurm16_pipe_slot.sv
// SLURM16 pipeline stage slot
// Holds one payload and its kill bit, with hold and kill from the controller
`timescale 1ns/100ps
`default_nettype none

module slurm16_pipe_slot #(
	parameter type payload_t = logic
) (
	input  wire           CLK,
	input  wire           RSTb,
	input  wire           hold,       // Keep current payload
	input  wire           kill,       // Mark slot as nop on this edge
	input  wire payload_t payload_in, // From the stage before
	input  wire           nop_in,
	output payload_t      payload,
	output logic          nop
);

	// Payload only moves, no reset needed
	always_ff @(posedge CLK) begin
		if (!hold)
			payload <= payload_in;
	end

	// Kill accumulates while held, so a stalled word still sees a branch
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			nop <= 1'b1; // Empty pipeline out of reset
		end else if (hold) begin
			nop <= nop | kill;
		end else begin
			nop <= nop_in | kill;
		end
	end

endmodule

`default_nettype wire

// File: slurm16_pipe_pkg.sv
// SLURM16 fetch and issue pipeline
// Shared widths, stage payload types, controller states and PC commands
`default_nettype none

package slurm16_pipe_pkg;

	localparam int word_bits = 16; // Instruction word
	localparam int addr_bits = 16; // Byte address
	localparam int reg_bits  = 4;  // Hazard register tag

	typedef logic [word_bits-1:0] word_t;
	typedef logic [addr_bits-2:0] fetch_addr_t; // Word address, byte bit 0 dropped
	typedef logic [reg_bits-1:0]  haz_reg_t;

	// Fetched word tagged with its own address
	typedef struct packed {
		word_t       ins;
		fetch_addr_t pc;
	} ins_word_t;

	// Word plus the hazard tags that travel with it through stages 1 to 3
	typedef struct packed {
		ins_word_t word;
		haz_reg_t  haz_reg;   // Destination register
		logic      mod_flags; // Writes the flags
	} tagged_word_t;

	// Controller states
	typedef enum logic [3:0] {
		st_reset       = 4'd0,
		st_pre_execute = 4'd1,
		st_execute     = 4'd2,
		st_halt        = 4'd3,
		st_halt2       = 4'd4,
		st_stall1      = 4'd5,
		st_stall2      = 4'd6,
		st_stall3      = 4'd7,
		st_ins_stall1  = 4'd8,
		st_ins_stall2  = 4'd9
	} ctrl_state_t;

	// Fetch address commands, one per cycle
	typedef enum logic [2:0] {
		pc_zero    = 3'd0, // Clear address and previous
		pc_advance = 3'd1, // Next word, previous takes old address
		pc_hold    = 3'd2,
		pc_rewind  = 3'd3, // Back to previous, undoes one lost fetch
		pc_load    = 3'd4, // Branch target
		pc_restart = 3'd5  // Address of the stage 2 word
	} pc_cmd_t;

endpackage

`default_nettype wire
